/* hdl/sdram_types_pkg.sv */
package sdram_types_pkg;

// Host word address, {bank, row, column} from the top down
typedef logic [23:0] haddr_t;

// One data word on the host side and on DQ
typedef logic [15:0] hdata_t;

// Row number, also the DRAM address bus width
typedef logic [12:0] row_t;

typedef logic [8:0] col_t;

typedef logic [1:0] bank_t;

endpackage

/* hdl/sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

typedef enum logic [2:0] {NOP, READ, WRITE, ACT, PRE, PALL, REF, MRS} command_t;

// Precharge all banks when set with PRE
localparam int A10_BIT = 10;

// Mode register fields
localparam int MR_BL_LSB = 0;
localparam int MR_CAS_LSB = 4;
localparam int MR_WB_BIT = 9;

// {RAS_N, CAS_N, WE_N} for each command
function automatic logic [2:0] pin_code(command_t c);
	case (c)
	READ: return 3'b101;
	WRITE: return 3'b100;
	ACT: return 3'b011;
	PRE, PALL: return 3'b010;
	REF: return 3'b001;
	MRS: return 3'b000;
	default: return 3'b111;
	endcase
endfunction

// Sequential bursts, single-word writes
function automatic sdram_types_pkg::row_t mode_word(int cas, int burst_log2);
	sdram_types_pkg::row_t mw;
	mw = '0;
	mw[MR_BL_LSB +: 3] = 3'(burst_log2);
	mw[MR_CAS_LSB +: 3] = 3'(cas);
	mw[MR_WB_BIT] = 1'b1;
	return mw;
endfunction

endpackage

/* hdl/request_queue.sv */
`timescale 1ns/1ps

module request_queue (
	input logic clkSDRAM,
	input logic n_reset,
	input logic req,
	input logic we,
	input sdram_types_pkg::haddr_t addr_in,
	input sdram_types_pkg::hdata_t data_in,
	input logic take,
	output logic rdy,
	output logic head_valid,
	output logic head_we,
	output sdram_types_pkg::haddr_t head_addr,
	output sdram_types_pkg::hdata_t head_data
);

logic [1:0] count;
logic wr_ptr, rd_ptr;
logic push;

logic we_q [2];
sdram_types_pkg::haddr_t addr_q [2];
sdram_types_pkg::hdata_t data_q [2];

// A take this cycle frees the slot
assign rdy = (count != 2'd2) | take;
assign push = req & rdy;

always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		wr_ptr <= 1'b0;
		rd_ptr <= 1'b0;
		count <= 2'd0;
	end else begin
		if (push)
			wr_ptr <= ~wr_ptr;
		if (take)
			rd_ptr <= ~rd_ptr;
		count <= count + 2'(push) - 2'(take);
	end
end

always_ff @(posedge clkSDRAM) begin
	if (push) begin
		we_q[wr_ptr] <= we;
		addr_q[wr_ptr] <= addr_in;
		data_q[wr_ptr] <= data_in;
	end
end

assign head_valid = count != 2'd0;
assign head_we = we_q[rd_ptr];
assign head_addr = addr_q[rd_ptr];
assign head_data = data_q[rd_ptr];

endmodule

/* hdl/sdram_bank.sv */
`timescale 1ns/1ps

module sdram_bank #(
	parameter int TRC = 8,
	parameter int TRAS = 6,
	parameter int TRP = 2,
	parameter int TRCD = 2,
	parameter int TDPL = 2
) (
	input logic clkSDRAM,
	input logic n_reset,
	input logic sel,
	input sdram_cmd_pkg::command_t cmd,
	input sdram_types_pkg::row_t row,
	output logic active,
	output logic match,
	output logic act_ok,
	output logic pre_ok,
	output logic rw_ok
);

localparam logic [7:0] CNT_MAX = 8'hff;

// Cycles since the last command of each kind, saturating
logic [7:0] since_act, since_pre, since_wr;
sdram_types_pkg::row_t open_row;
logic do_act, do_pre, do_wr;

function automatic logic [7:0] sat_inc(logic [7:0] c);
	return (c == CNT_MAX) ? c : c + 8'd1;
endfunction

assign do_act = sel & (cmd == sdram_cmd_pkg::ACT);
assign do_pre = sel & (cmd == sdram_cmd_pkg::PRE || cmd == sdram_cmd_pkg::PALL);
assign do_wr = sel & (cmd == sdram_cmd_pkg::WRITE);

always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		active <= 1'b0;
		since_act <= CNT_MAX;
		since_pre <= CNT_MAX;
		since_wr <= CNT_MAX;
	end else begin
		if (do_act)
			active <= 1'b1;
		else if (do_pre)
			active <= 1'b0;
		since_act <= do_act ? 8'd1 : sat_inc(since_act);
		since_pre <= do_pre ? 8'd1 : sat_inc(since_pre);
		since_wr <= do_wr ? 8'd1 : sat_inc(since_wr);
	end
end

always_ff @(posedge clkSDRAM) begin
	if (do_act)
		open_row <= row;
end

assign match = active & (open_row == row);

assign act_ok = (since_pre >= TRP) && (since_act >= TRC);
assign pre_ok = (since_act >= TRAS) && (since_wr >= TDPL);
assign rw_ok = since_act >= TRCD;

endmodule

/* hdl/sdram_sequencer.sv */
`timescale 1ns/1ps

module sdram_sequencer #(
	parameter int CAS = 2,
	parameter int BURST = 3,
	parameter int TINIT = 13300,
	parameter int TREFC = 1039,
	parameter int TRC = 8,
	parameter int TRAS = 6,
	parameter int TRP = CAS,
	parameter int TMRD = 2,
	parameter int TDPL = 2
) (
	input logic clkSDRAM,
	input logic n_reset,
	input logic en,
	input logic head_valid,
	input logic head_we,
	input sdram_types_pkg::haddr_t head_addr,
	input sdram_types_pkg::hdata_t head_data,
	input logic [3:0] active,
	input logic [3:0] match,
	input logic [3:0] act_ok,
	input logic [3:0] pre_ok,
	input logic [3:0] rw_ok,
	output logic take,
	output sdram_cmd_pkg::command_t cmd,
	output logic [3:0] sel,
	output sdram_types_pkg::row_t row,
	output logic rd_issue,
	output sdram_types_pkg::haddr_t rd_addr,
	output sdram_types_pkg::row_t DRAM_ADDR,
	output sdram_types_pkg::bank_t DRAM_BA,
	output logic [1:0] DRAM_DQM,
	output logic DRAM_CKE,
	output logic DRAM_CLK,
	output logic DRAM_CS_N,
	output logic DRAM_RAS_N,
	output logic DRAM_CAS_N,
	output logic DRAM_WE_N,
	inout wire sdram_types_pkg::hdata_t DRAM_DQ
);

localparam int BURST_LEN = 2 ** BURST;

typedef enum logic [2:0] {
	Reset, Init, InitPALL, Precharge, Refresh, Execute, Active
} state_t;

state_t state, state_next;
logic [15:0] cnt, cnt_load;
logic mode_pending;
logic execute;
logic [3:0] burst;
logic [3:0] wrdelay;

sdram_types_pkg::bank_t head_ba;
sdram_types_pkg::col_t head_col;

sdram_types_pkg::row_t addr_next;
sdram_types_pkg::bank_t ba_next;
logic ras_n_next, cas_n_next, we_n_next;
logic dq_oe;
sdram_types_pkg::hdata_t dq_out;

assign {head_ba, row, head_col} = head_addr;

always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		state <= Reset;
		cnt <= 16'd0;
	end else if (cnt == 16'd0) begin
		state <= state_next;
		cnt <= cnt_load;
	end else begin
		cnt <= cnt - 16'd1;
	end
end

// Mode load flag, read burst busy and read-to-write gap
always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		mode_pending <= 1'b1;
		burst <= 4'd0;
		wrdelay <= 4'd0;
	end else begin
		if (cmd == sdram_cmd_pkg::MRS)
			mode_pending <= 1'b0;
		if (cmd == sdram_cmd_pkg::READ)
			burst <= 4'(BURST_LEN - 1);
		else if (burst != 4'd0)
			burst <= burst - 4'd1;
		if (cmd == sdram_cmd_pkg::READ)
			wrdelay <= 4'(CAS + BURST_LEN);
		else if (wrdelay != 4'd0)
			wrdelay <= wrdelay - 4'd1;
	end
end

always_comb begin
	state_next = state;
	cnt_load = 16'd0;
	cmd = sdram_cmd_pkg::NOP;
	execute = 1'b0;
	case (state)
	Reset: begin
		state_next = Init;
		cnt_load = 16'(TINIT - 1);
	end
	Init: begin
		state_next = InitPALL;
		cnt_load = 16'(TRP - 1);
		if (cnt == 16'd0)
			cmd = sdram_cmd_pkg::PALL;
	end
	InitPALL, Precharge: begin
		state_next = (state == InitPALL) ? Precharge : Refresh;
		cnt_load = 16'(TRC - 1);
		if (cnt == 16'd0)
			cmd = sdram_cmd_pkg::REF;
	end
	Refresh: begin
		if (mode_pending) begin
			cnt_load = 16'(TMRD - 1);
			if (cnt == 16'd0)
				cmd = sdram_cmd_pkg::MRS;
		end else begin
			// Execute, Active, Precharge and Refresh fill one refresh period
			state_next = Execute;
			cnt_load = 16'(TREFC - TRP - TRC - 2);
		end
	end
	Execute: begin
		state_next = Active;
		execute = 1'b1;
	end
	Active: begin
		state_next = Precharge;
		cnt_load = 16'(TRP - 1);
		cmd = sdram_cmd_pkg::PALL;
	end
	default: state_next = Reset;
	endcase

	// Leave room for the PALL that ends the Active period
	if (execute && head_valid && burst == 4'd0) begin
		if (!active[head_ba]) begin
			if (act_ok[head_ba] && cnt >= TRAS)
				cmd = sdram_cmd_pkg::ACT;
		end else if (!match[head_ba]) begin
			if (pre_ok[head_ba])
				cmd = sdram_cmd_pkg::PRE;
		end else if (rw_ok[head_ba]) begin
			if (!head_we) begin
				if (cnt >= BURST_LEN)
					cmd = sdram_cmd_pkg::READ;
			end else if (wrdelay == 4'd0 && cnt >= TDPL) begin
				cmd = sdram_cmd_pkg::WRITE;
			end
		end
	end
end

assign take = (cmd == sdram_cmd_pkg::READ) || (cmd == sdram_cmd_pkg::WRITE);
assign rd_issue = cmd == sdram_cmd_pkg::READ;
assign rd_addr = head_addr;
assign sel = (cmd == sdram_cmd_pkg::PALL) ? 4'b1111 : 4'b0001 << head_ba;

always_comb begin
	{ras_n_next, cas_n_next, we_n_next} = sdram_cmd_pkg::pin_code(cmd);
	ba_next = head_ba;
	addr_next = '0;
	case (cmd)
	sdram_cmd_pkg::ACT: addr_next = row;
	sdram_cmd_pkg::READ, sdram_cmd_pkg::WRITE: addr_next = sdram_types_pkg::row_t'(head_col);
	sdram_cmd_pkg::PALL: addr_next[sdram_cmd_pkg::A10_BIT] = 1'b1;
	sdram_cmd_pkg::MRS: begin
		ba_next = '0;
		addr_next = sdram_cmd_pkg::mode_word(CAS, BURST);
	end
	default: ;
	endcase
end

always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		DRAM_CKE <= 1'b0;
		DRAM_RAS_N <= 1'b1;
		DRAM_CAS_N <= 1'b1;
		DRAM_WE_N <= 1'b1;
		DRAM_BA <= '0;
		DRAM_ADDR <= '0;
		dq_oe <= 1'b0;
	end else begin
		DRAM_CKE <= 1'b1;
		DRAM_RAS_N <= ras_n_next;
		DRAM_CAS_N <= cas_n_next;
		DRAM_WE_N <= we_n_next;
		DRAM_BA <= ba_next;
		DRAM_ADDR <= addr_next;
		dq_oe <= cmd == sdram_cmd_pkg::WRITE;
	end
end

always_ff @(posedge clkSDRAM)
	dq_out <= head_data;

assign DRAM_DQ = dq_oe ? dq_out : 'z;

// All byte lanes always enabled
assign DRAM_DQM = 2'b00;
assign DRAM_CLK = clkSDRAM;
assign DRAM_CS_N = ~en;

endmodule

/* hdl/read_return.sv */
`timescale 1ns/1ps

module read_return #(
	parameter int CAS = 2,
	parameter int BURST = 3
) (
	input logic clkSDRAM,
	input logic n_reset,
	input logic rd_issue,
	input sdram_types_pkg::haddr_t rd_addr,
	input sdram_types_pkg::hdata_t dq,
	output logic rdy_out,
	output sdram_types_pkg::haddr_t addr_out,
	output sdram_types_pkg::hdata_t data_out
);

// Pin register plus CAS cycles in the device
localparam int DEPTH = CAS + 1;
localparam sdram_types_pkg::haddr_t LOW_MASK = sdram_types_pkg::haddr_t'((1 << BURST) - 1);

logic [3:0] burst_cnt;
logic [DEPTH-1:0] rd_pipe, burst_pipe;
sdram_types_pkg::haddr_t addr_pipe [DEPTH];

always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		burst_cnt <= 4'd0;
		rd_pipe <= '0;
		burst_pipe <= '0;
		rdy_out <= 1'b0;
	end else begin
		if (rd_issue)
			burst_cnt <= 4'((2 ** BURST) - 1);
		else if (burst_cnt != 4'd0)
			burst_cnt <= burst_cnt - 4'd1;
		rd_pipe <= {rd_pipe[DEPTH-2:0], rd_issue};
		burst_pipe <= {burst_pipe[DEPTH-2:0], burst_cnt != 4'd0};
		rdy_out <= rd_pipe[DEPTH-1] | burst_pipe[DEPTH-1];
	end
end

always_ff @(posedge clkSDRAM) begin
	addr_pipe[0] <= rd_addr;
	for (int i = 1; i < DEPTH; i++)
		addr_pipe[i] <= addr_pipe[i-1];
end

// Later burst words wrap within the aligned block
always_ff @(posedge clkSDRAM) begin
	if (rd_pipe[DEPTH-1])
		addr_out <= addr_pipe[DEPTH-1];
	else if (burst_pipe[DEPTH-1])
		addr_out <= (addr_out & ~LOW_MASK) | ((addr_out + 24'd1) & LOW_MASK);
	data_out <= dq;
end

endmodule

/* hdl/sdram_subsys.sv */
`timescale 1ns/1ps

module sdram_subsys #(
	parameter int CAS = 2,
	parameter int BURST = 3,
	parameter int TINIT = 13300,
	parameter int TREFC = 1039,
	parameter int TRC = 8,
	parameter int TRAS = 6,
	parameter int TRP = CAS,
	parameter int TMRD = 2,
	parameter int TRCD = CAS,
	parameter int TDPL = 2
) (
	input logic clkSDRAM,
	input logic n_reset,
	input logic en,
	input logic req,
	input logic we,
	input sdram_types_pkg::haddr_t addr_in,
	input sdram_types_pkg::hdata_t data_in,
	output logic rdy,
	output logic rdy_out,
	output sdram_types_pkg::haddr_t addr_out,
	output sdram_types_pkg::hdata_t data_out,
	output sdram_types_pkg::row_t DRAM_ADDR,
	output sdram_types_pkg::bank_t DRAM_BA,
	output logic [1:0] DRAM_DQM,
	output logic DRAM_CKE,
	output logic DRAM_CLK,
	output logic DRAM_CS_N,
	output logic DRAM_RAS_N,
	output logic DRAM_CAS_N,
	output logic DRAM_WE_N,
	inout wire sdram_types_pkg::hdata_t DRAM_DQ
);

logic head_valid, head_we, take, rd_issue;
sdram_types_pkg::haddr_t head_addr, rd_addr;
sdram_types_pkg::hdata_t head_data;
sdram_cmd_pkg::command_t cmd;
sdram_types_pkg::row_t row;
logic [3:0] sel, active, match, act_ok, pre_ok, rw_ok;

request_queue i_request_queue (
	.clkSDRAM, .n_reset, .req, .we, .addr_in, .data_in, .take,
	.rdy, .head_valid, .head_we, .head_addr, .head_data
);

sdram_sequencer #(
	.CAS(CAS), .BURST(BURST), .TINIT(TINIT), .TREFC(TREFC), .TRC(TRC),
	.TRAS(TRAS), .TRP(TRP), .TMRD(TMRD), .TDPL(TDPL)
) i_sequencer (
	.clkSDRAM, .n_reset, .en, .head_valid, .head_we, .head_addr, .head_data,
	.active, .match, .act_ok, .pre_ok, .rw_ok,
	.take, .cmd, .sel, .row, .rd_issue, .rd_addr,
	.DRAM_ADDR, .DRAM_BA, .DRAM_DQM, .DRAM_CKE, .DRAM_CLK, .DRAM_CS_N,
	.DRAM_RAS_N, .DRAM_CAS_N, .DRAM_WE_N, .DRAM_DQ
);

for (genvar b = 0; b < 4; b++) begin : gen_bank
	sdram_bank #(
		.TRC(TRC), .TRAS(TRAS), .TRP(TRP), .TRCD(TRCD), .TDPL(TDPL)
	) i_bank (
		.clkSDRAM, .n_reset, .sel(sel[b]), .cmd, .row,
		.active(active[b]), .match(match[b]), .act_ok(act_ok[b]),
		.pre_ok(pre_ok[b]), .rw_ok(rw_ok[b])
	);
end

read_return #(
	.CAS(CAS), .BURST(BURST)
) i_read_return (
	.clkSDRAM, .n_reset, .rd_issue, .rd_addr, .dq(DRAM_DQ),
	.rdy_out, .addr_out, .data_out
);

endmodule

/* testbench/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model (
	input logic clk,
	input logic cke,
	input logic cs_n,
	input logic ras_n,
	input logic cas_n,
	input logic we_n,
	input sdram_types_pkg::bank_t ba,
	input sdram_types_pkg::row_t addr,
	inout wire sdram_types_pkg::hdata_t dq
);

// Sparse storage, words never written read as zero
sdram_types_pkg::hdata_t mem [sdram_types_pkg::haddr_t];
sdram_types_pkg::row_t open_row [4];
sdram_types_pkg::row_t mode_reg;
sdram_cmd_pkg::command_t cmd_log [$];

// Read words waiting for their output edge
int due_q [$];
sdram_types_pkg::haddr_t word_q [$];

int cyc;
int last_ref;
int max_ref_gap;
logic drive_en;
sdram_types_pkg::hdata_t drive_val;

assign dq = drive_en ? drive_val : 'z;

initial begin
	drive_en = 1'b0;
	cyc = 0;
	last_ref = -1;
	max_ref_gap = 0;
	mode_reg = 13'h023;
end

function automatic sdram_cmd_pkg::command_t decode();
	if (cs_n)
		return sdram_cmd_pkg::NOP;
	case ({ras_n, cas_n, we_n})
	3'b101: return sdram_cmd_pkg::READ;
	3'b100: return sdram_cmd_pkg::WRITE;
	3'b011: return sdram_cmd_pkg::ACT;
	3'b010: return addr[sdram_cmd_pkg::A10_BIT] ? sdram_cmd_pkg::PALL : sdram_cmd_pkg::PRE;
	3'b001: return sdram_cmd_pkg::REF;
	3'b000: return sdram_cmd_pkg::MRS;
	default: return sdram_cmd_pkg::NOP;
	endcase
endfunction

always @(posedge clk) begin
	sdram_cmd_pkg::command_t c;
	sdram_types_pkg::haddr_t a;
	logic [8:0] mask;
	int cl;
	cyc = cyc + 1;
	if (!cke) begin
		// Device held in reset, forget everything in flight
		due_q.delete();
		word_q.delete();
		cmd_log.delete();
		last_ref = -1;
		max_ref_gap = 0;
		drive_en <= 1'b0;
	end else begin
		c = decode();
		if (c != sdram_cmd_pkg::NOP)
			cmd_log.push_back(c);
		case (c)
		sdram_cmd_pkg::ACT: open_row[ba] = addr;
		sdram_cmd_pkg::WRITE: mem[{ba, open_row[ba], addr[8:0]}] = dq;
		sdram_cmd_pkg::READ: begin
			mask = 9'((1 << mode_reg[2:0]) - 1);
			cl = mode_reg[6:4];
			for (int i = 0; i <= int'(mask); i++) begin
				a = {ba, open_row[ba], (addr[8:0] & ~mask) | ((addr[8:0] + 9'(i)) & mask)};
				due_q.push_back(cyc + cl + i);
				word_q.push_back(a);
			end
		end
		sdram_cmd_pkg::REF: begin
			if (last_ref >= 0 && cyc - last_ref > max_ref_gap)
				max_ref_gap = cyc - last_ref;
			last_ref = cyc;
		end
		sdram_cmd_pkg::MRS: mode_reg = addr;
		default: ;
		endcase
		if (due_q.size() > 0 && due_q[0] == cyc + 1) begin
			a = word_q.pop_front();
			void'(due_q.pop_front());
			drive_en <= 1'b1;
			drive_val <= mem.exists(a) ? mem[a] : 16'h0000;
		end else begin
			drive_en <= 1'b0;
		end
	end
end

endmodule

/* testbench/sdram_checker.sv */
`timescale 1ns/1ps

module sdram_checker #(
	parameter int TREFC = 400,
	parameter int TRC = 8
) (
	input logic clkSDRAM,
	input logic n_reset,
	input sdram_cmd_pkg::command_t cmd,
	input sdram_types_pkg::hdata_t head_data,
	input sdram_types_pkg::hdata_t DRAM_DQ
);

logic mrs_seen, ref_seen;
logic [15:0] since_ref;
int fail_count = 0;

always_ff @(posedge clkSDRAM, negedge n_reset) begin
	if (!n_reset) begin
		mrs_seen <= 1'b0;
		ref_seen <= 1'b0;
		since_ref <= 16'd0;
	end else begin
		if (cmd == sdram_cmd_pkg::MRS)
			mrs_seen <= 1'b1;
		if (cmd == sdram_cmd_pkg::REF) begin
			ref_seen <= 1'b1;
			since_ref <= 16'd0;
		end else if (since_ref != 16'hffff) begin
			since_ref <= since_ref + 16'd1;
		end
	end
end

assert property (@(posedge clkSDRAM) disable iff (!n_reset)
	(cmd inside {sdram_cmd_pkg::READ, sdram_cmd_pkg::WRITE, sdram_cmd_pkg::ACT}) |-> mrs_seen)
	else begin
		$error("READ, WRITE or ACT issued before the mode register load");
		fail_count++;
	end

// Controller alone drives DQ with the head word in the cycle after WRITE
assert property (@(posedge clkSDRAM) disable iff (!n_reset)
	$past(cmd == sdram_cmd_pkg::WRITE) |-> DRAM_DQ === $past(head_data))
	else begin
		$error("DQ does not carry the write word in the cycle after WRITE");
		fail_count++;
	end

// Gap between REF commands stays within one refresh period plus tRC
assert property (@(posedge clkSDRAM) disable iff (!n_reset)
	ref_seen |-> since_ref < 16'(TREFC + TRC))
	else begin
		$error("REF spacing exceeds the refresh bound");
		fail_count++;
	end

endmodule

/* testbench/tb_sdram_subsys.sv */
`timescale 1ns/1ps

module tb_sdram_subsys;

localparam int CAS = 2;
localparam int BURST = 3;
localparam int BL = 2 ** BURST;
localparam int TINIT = 50;
localparam int TREFC = 400;
localparam int TRC = 8;
localparam int WAIT_MAX = 2000;

logic clkSDRAM, n_reset, req, we;
sdram_types_pkg::haddr_t addr_in, addr_out;
sdram_types_pkg::hdata_t data_in, data_out;
logic rdy, rdy_out;
sdram_types_pkg::row_t DRAM_ADDR;
sdram_types_pkg::bank_t DRAM_BA;
logic [1:0] DRAM_DQM;
logic DRAM_CKE, DRAM_CLK, DRAM_CS_N, DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N;
wire sdram_types_pkg::hdata_t DRAM_DQ;

int seed = 61;
int errors = 0;
int timeouts = 0;
logic rdy_was_low;

sdram_types_pkg::hdata_t shadow [sdram_types_pkg::haddr_t];
// Expected read words in return order
sdram_types_pkg::haddr_t exp_addr_q [$];
sdram_types_pkg::hdata_t exp_data_q [$];
sdram_types_pkg::haddr_t seen_q [$];

sdram_subsys #(.CAS(CAS), .BURST(BURST), .TINIT(TINIT), .TREFC(TREFC), .TRC(TRC)) i_sdram_subsys (
	.clkSDRAM, .n_reset, .en(1'b1), .req, .we, .addr_in, .data_in,
	.rdy, .rdy_out, .addr_out, .data_out,
	.DRAM_ADDR, .DRAM_BA, .DRAM_DQM, .DRAM_CKE, .DRAM_CLK, .DRAM_CS_N,
	.DRAM_RAS_N, .DRAM_CAS_N, .DRAM_WE_N, .DRAM_DQ
);

sdram_model i_model (
	.clk(DRAM_CLK), .cke(DRAM_CKE), .cs_n(DRAM_CS_N), .ras_n(DRAM_RAS_N),
	.cas_n(DRAM_CAS_N), .we_n(DRAM_WE_N), .ba(DRAM_BA), .addr(DRAM_ADDR), .dq(DRAM_DQ)
);

bind sdram_sequencer sdram_checker #(.TREFC(TREFC), .TRC(TRC)) i_checker (
	.clkSDRAM, .n_reset, .cmd, .head_data, .DRAM_DQ
);

always #5 clkSDRAM = ~clkSDRAM;

// Return words are compared against the values captured at request time
always @(negedge clkSDRAM) begin
	sdram_types_pkg::haddr_t ea;
	sdram_types_pkg::hdata_t ed;
	// Both byte lanes stay enabled
	if (n_reset && DRAM_DQM !== 2'b00) begin
		errors++;
		$display("** Error at %0t: DRAM_DQM = %b, expected 00", $time, DRAM_DQM);
	end
	if (rdy_out) begin
		seen_q.push_back(addr_out);
		if (exp_addr_q.size() == 0) begin
			errors++;
			$display("Unexpected read word at %0t for address %h", $time, addr_out);
		end else begin
			ea = exp_addr_q.pop_front();
			ed = exp_data_q.pop_front();
			if (addr_out !== ea) begin
				errors++;
				$display("** Error at %0t: addr_out = %h, expected %h", $time, addr_out, ea);
			end
			if (data_out !== ed) begin
				errors++;
				$display("** Error at %0t: data_out = %h, expected %h", $time, data_out, ed);
			end
		end
	end
end

function automatic sdram_types_pkg::hdata_t shadow_word(sdram_types_pkg::haddr_t a);
	return shadow.exists(a) ? shadow[a] : 16'h0000;
endfunction

// Called at a falling edge; returns at the falling edge after acceptance
task automatic send(input logic w, input sdram_types_pkg::haddr_t a);
	int t;
	sdram_types_pkg::haddr_t wa;
	t = 0;
	req = 1'b1;
	we = w;
	addr_in = a;
	data_in = 16'($random(seed));
	while (!rdy && t < WAIT_MAX) begin
		rdy_was_low = 1'b1;
		t++;
		@(negedge clkSDRAM);
	end
	if (t >= WAIT_MAX) begin
		timeouts++;
		$display("Timeout: request for address %h never accepted", a);
	end else if (w) begin
		shadow[a] = data_in;
	end else begin
		for (int i = 0; i < BL; i++) begin
			wa = (a & ~24'(BL - 1)) | ((a + 24'(i)) & 24'(BL - 1));
			exp_addr_q.push_back(wa);
			exp_data_q.push_back(shadow_word(wa));
		end
	end
	@(negedge clkSDRAM);
	req = 1'b0;
endtask

task automatic wait_drain();
	int t;
	t = 0;
	while (exp_addr_q.size() != 0 && t < WAIT_MAX) begin
		t++;
		@(negedge clkSDRAM);
	end
	if (t >= WAIT_MAX) begin
		timeouts++;
		$display("Timeout: %0d read words never returned", exp_addr_q.size());
	end
	repeat (4) @(negedge clkSDRAM);
endtask

task automatic check_init();
	int t;
	t = 0;
	repeat (2) @(negedge clkSDRAM);
	if (DRAM_CKE !== 1'b1 || {DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N} !== 3'b111) begin
		errors++;
		$display("Pins after reset are not NOP with CKE high at %0t", $time);
	end
	while (i_model.cmd_log.size() < 4 && t < WAIT_MAX) begin
		t++;
		@(negedge clkSDRAM);
	end
	if (t >= WAIT_MAX) begin
		timeouts++;
		$display("Timeout: initialisation commands never appeared");
	end else if (i_model.cmd_log[0] != sdram_cmd_pkg::PALL || i_model.cmd_log[1] != sdram_cmd_pkg::REF
			|| i_model.cmd_log[2] != sdram_cmd_pkg::REF || i_model.cmd_log[3] != sdram_cmd_pkg::MRS) begin
		errors++;
		$display("Initialisation order is not PALL, REF, REF, MRS");
	end
	if (i_model.mode_reg[2:0] !== 3'(BURST) || i_model.mode_reg[6:4] !== 3'(CAS)
			|| i_model.mode_reg[9] !== 1'b1) begin
		errors++;
		$display("** Error at %0t: mode_reg = %h, expected CAS %0d and burst %0d", $time,
			i_model.mode_reg, CAS, BURST);
	end
endtask

task automatic apply_reset();
	n_reset = 1'b0;
	repeat (3) @(negedge clkSDRAM);
	n_reset = 1'b1;
endtask

task automatic write_then_read();
	sdram_types_pkg::haddr_t base, wa;
	base = 24'h40_1a08;
	for (int i = 0; i < BL; i++)
		send(1'b1, base + 24'(i));
	seen_q.delete();
	send(1'b0, base + 24'd5);
	wait_drain();
	if (seen_q.size() != BL) begin
		errors++;
		$display("** Error at %0t: strobe count = %0d, expected %0d", $time, seen_q.size(), BL);
	end else begin
		for (int i = 0; i < BL; i++) begin
			wa = base | ((24'd5 + 24'(i)) & 24'(BL - 1));
			if (seen_q[i] !== wa) begin
				errors++;
				$display("** Error at %0t: addr_out = %h, expected %h", $time, seen_q[i], wa);
			end
		end
	end
endtask

task automatic row_conflict();
	sdram_types_pkg::haddr_t a0, a1;
	for (int k = 0; k < 4; k++) begin
		// Same bank, two rows, then two banks
		a0 = {2'd2, 13'd7, 9'(8 * k)};
		a1 = (k < 2) ? {2'd2, 13'd9, 9'(8 * k)} : {2'd3, 13'd9, 9'(8 * k)};
		send(1'b1, a0);
		send(1'b1, a1);
		send(1'b0, a0);
		send(1'b0, a1);
	end
	wait_drain();
endtask

task automatic refresh_load();
	sdram_types_pkg::haddr_t a;
	for (int n = 0; n < 60; n++) begin
		a = {2'($random(seed)), 13'($random(seed) & 3), 9'($random(seed) & 31)};
		send(1'($random(seed)), a);
		repeat ($random(seed) & 15) @(negedge clkSDRAM);
	end
	wait_drain();
	if (i_model.max_ref_gap > TREFC + TRC) begin
		errors++;
		$display("** Error at %0t: max_ref_gap = %0d, expected at most %0d", $time,
			i_model.max_ref_gap, TREFC + TRC);
	end
endtask

task automatic back_pressure();
	rdy_was_low = 1'b0;
	for (int n = 0; n < 12; n++)
		send(n[0], {2'd1, 13'd5, 9'(n * 3)});
	if (!rdy_was_low) begin
		errors++;
		$display("rdy never fell while requests arrived every cycle");
	end
	wait_drain();
endtask

task automatic reset_in_burst();
	int t;
	t = 0;
	send(1'b0, {2'd0, 13'd3, 9'd16});
	while (!rdy_out && t < WAIT_MAX) begin
		t++;
		@(negedge clkSDRAM);
	end
	if (t >= WAIT_MAX) begin
		timeouts++;
		$display("Timeout: read burst never started");
	end
	n_reset = 1'b0;
	#1;
	if (rdy_out !== 1'b0 || DRAM_CKE !== 1'b0
			|| {DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N} !== 3'b111) begin
		errors++;
		$display("Outputs did not return to reset values at %0t", $time);
	end
	exp_addr_q.delete();
	exp_data_q.delete();
	repeat (3) @(negedge clkSDRAM);
	n_reset = 1'b1;
	check_init();
endtask

initial begin
	clkSDRAM = 1'b0;
	n_reset = 1'b0;
	req = 1'b0;
	we = 1'b0;
	addr_in = '0;
	data_in = '0;
	apply_reset();
	check_init();
	write_then_read();
	row_conflict();
	refresh_load();
	back_pressure();
	reset_in_burst();
	$display("Errors: %0d, timeouts: %0d, assertion failures: %0d", errors, timeouts,
		i_sdram_subsys.i_sequencer.i_checker.fail_count);
	if (errors == 0 && timeouts == 0 && i_sdram_subsys.i_sequencer.i_checker.fail_count == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule

/* project.f */
hdl/sdram_types_pkg.sv
hdl/sdram_cmd_pkg.sv
hdl/request_queue.sv
hdl/sdram_bank.sv
hdl/sdram_sequencer.sv
hdl/read_return.sv
hdl/sdram_subsys.sv
testbench/sdram_model.sv
testbench/sdram_checker.sv
testbench/tb_sdram_subsys.sv
